// ==== fpu_defs.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and depth of the FP issue slot
// FPU_DW is fixed at 32, because the exec unit decodes binary32 fields only
// FPU_IQ_DEPTH sets the queue size; the priority select scales with it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// Operand width, single precision
`define FPU_DW 32

// Architectural FP register address
`define FPU_REG_AW 5

// Reorder-buffer id, 16 in flight
`define FPU_ID_W 4

// Issue queue entries
// Two more items fit in the exec stages on top of these
`define FPU_IQ_DEPTH 4

`endif

// ==== fpu_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the FP issue slot
// Code 0 of the micro-op enum is a bubble and must never be dispatched
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fpu_defs.svh"

package fpu_pkg;

   // Micro-op codes, numbered from 1 so the one-hot bus is code minus one
   typedef enum logic [3:0]
   {
      UOP_NONE   = 4'd0,   // Bubble
      UOP_FSGNJ  = 4'd1,
      UOP_FSGNJN = 4'd2,
      UOP_FSGNJX = 4'd3,
      UOP_FMIN   = 4'd4,
      UOP_FMAX   = 4'd5,
      UOP_FEQ    = 4'd6,
      UOP_FLT    = 4'd7,
      UOP_FLE    = 4'd8
   } fpu_uop_e;

   typedef logic [`FPU_DW-1:0]     fpu_word_t;  // Operand / result
   typedef logic [`FPU_ID_W-1:0]   fpu_id_t;    // ROB tag
   typedef logic [`FPU_REG_AW-1:0] fpu_reg_t;   // Source register

   // Quiet NaN returned by FMIN/FMAX when both inputs are NaN
   localparam fpu_word_t FPU_CANON_NAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

// ==== fpu_issue_queue.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Out-of-order issue queue, FPU_IQ_DEPTH entries
// Issues lowest ready index, not oldest by age; wakeup takes one cycle
// o_issue_ready looks at current occupancy only, no same-cycle reuse
// Dispatch must keep inputs stable while valid is high and ready low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fpu_defs.svh"

module fpu_issue_queue
(
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_flush,
   // Dispatch
   input  wire                       i_issue_valid,
   output logic                      o_issue_ready,
   input  wire fpu_pkg::fpu_uop_e    i_uop,
   input  wire fpu_pkg::fpu_id_t     i_id,
   input  wire                       i_rs1_rdy,
   input  wire fpu_pkg::fpu_word_t   i_rs1_dat,
   input  wire fpu_pkg::fpu_reg_t    i_rs1_addr,
   input  wire                       i_rs2_rdy,
   input  wire fpu_pkg::fpu_word_t   i_rs2_dat,
   input  wire fpu_pkg::fpu_reg_t    i_rs2_addr,
   // Writeback bypass
   input  wire                       i_byp_valid,
   input  wire                       i_byp_we,
   input  wire fpu_pkg::fpu_word_t   i_byp_data,
   input  wire fpu_pkg::fpu_reg_t    i_byp_addr,
   // To exec unit
   output logic                      o_fu_valid,
   input  wire                       i_fu_ready,
   output fpu_pkg::fpu_uop_e         o_fu_uop,
   output fpu_pkg::fpu_id_t          o_fu_id,
   output fpu_pkg::fpu_word_t        o_fu_rs1,
   output fpu_pkg::fpu_word_t        o_fu_rs2
);
   import fpu_pkg::*;

   localparam int DEPTH = `FPU_IQ_DEPTH;
   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Control state, per entry
   logic [DEPTH-1:0] ent_vld;
   logic [DEPTH-1:0] rs1_rdy;
   logic [DEPTH-1:0] rs2_rdy;

   // Payload, no reset
   fpu_uop_e  ent_uop  [DEPTH];
   fpu_id_t   ent_id   [DEPTH];
   fpu_word_t rs1_dat  [DEPTH];
   fpu_word_t rs2_dat  [DEPTH];
   fpu_reg_t  rs1_addr [DEPTH];
   fpu_reg_t  rs2_addr [DEPTH];

   logic [DEPTH-1:0] wake1;          // Stored rs1 hit by bypass
   logic [DEPTH-1:0] wake2;
   logic [DEPTH-1:0] ent_go;         // Both operands ready
   logic             byp_hit;
   logic             in1_wake;       // Arriving rs1 hit in same cycle
   logic             in2_wake;
   logic             acc;            // Dispatch handshake
   logic             iss;            // FU handshake
   logic [IDX_W-1:0] free_idx;
   logic [IDX_W-1:0] sel_idx;

   assign byp_hit  = i_byp_valid & i_byp_we;
   assign in1_wake = byp_hit & ~i_rs1_rdy & (i_rs1_addr == i_byp_addr);
   assign in2_wake = byp_hit & ~i_rs2_rdy & (i_rs2_addr == i_byp_addr);

   always_comb
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         wake1[i]  = ent_vld[i] & byp_hit & ~rs1_rdy[i] & (rs1_addr[i] == i_byp_addr);
         wake2[i]  = ent_vld[i] & byp_hit & ~rs2_rdy[i] & (rs2_addr[i] == i_byp_addr);
         ent_go[i] = ent_vld[i] & rs1_rdy[i] & rs2_rdy[i];   // Registered flags only
      end
   end

   // Lowest free slot and lowest ready slot, scanned downwards so index 0 wins
   always_comb
   begin
      free_idx = '0;
      sel_idx  = '0;
      for (int i = DEPTH-1; i >= 0; i--)
      begin
         if (!ent_vld[i])
            free_idx = IDX_W'(i);
         if (ent_go[i])
            sel_idx = IDX_W'(i);
      end
   end

   assign o_issue_ready = ~&ent_vld;  // Any hole
   assign acc           = i_issue_valid & o_issue_ready;

   // Selected entry straight to the FU
   assign o_fu_valid = |ent_go;
   assign o_fu_uop   = ent_uop[sel_idx];
   assign o_fu_id    = ent_id[sel_idx];
   assign o_fu_rs1   = rs1_dat[sel_idx];
   assign o_fu_rs2   = rs2_dat[sel_idx];
   assign iss        = o_fu_valid & i_fu_ready;

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         ent_vld <= '0;
         rs1_rdy <= '0;
         rs2_rdy <= '0;
      end
      else if (i_flush)
         ent_vld <= '0;     // Drops this cycle's dispatch and issue too
      else
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            if (wake1[i])
               rs1_rdy[i] <= 1'b1;
            if (wake2[i])
               rs2_rdy[i] <= 1'b1;
         end
         // free_idx is never the selected entry, both can land in one cycle
         if (iss)
            ent_vld[sel_idx] <= 1'b0;
         if (acc)
         begin
            ent_vld[free_idx] <= 1'b1;
            rs1_rdy[free_idx] <= i_rs1_rdy | in1_wake;
            rs2_rdy[free_idx] <= i_rs2_rdy | in2_wake;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < DEPTH; i++)
      begin
         if (wake1[i])
            rs1_dat[i] <= i_byp_data;  // Capture forwarded value
         if (wake2[i])
            rs2_dat[i] <= i_byp_data;
      end
      if (acc)
      begin
         ent_uop[free_idx]  <= i_uop;
         ent_id[free_idx]   <= i_id;
         rs1_addr[free_idx] <= i_rs1_addr;
         rs2_addr[free_idx] <= i_rs2_addr;
         rs1_dat[free_idx]  <= in1_wake ? i_byp_data : i_rs1_dat;
         rs2_dat[free_idx]  <= in2_wake ? i_byp_data : i_rs2_dat;
      end
   end

endmodule

`default_nettype wire

// ==== fpu_exec.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage FP sign-injection, min/max and compare unit, binary32 only
// No flags raised, signalling and quiet NaN are treated alike
// Result and id held while o_wb_valid is high and i_wb_ready low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fpu_defs.svh"

module fpu_exec
(
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_flush,
   // From issue queue
   input  wire                       i_fu_valid,
   output logic                      o_fu_ready,
   input  wire fpu_pkg::fpu_uop_e    i_fu_uop,
   input  wire fpu_pkg::fpu_id_t     i_fu_id,
   input  wire fpu_pkg::fpu_word_t   i_fu_rs1,
   input  wire fpu_pkg::fpu_word_t   i_fu_rs2,
   // To writeback
   output logic                      o_wb_valid,
   input  wire                       i_wb_ready,
   output fpu_pkg::fpu_word_t        o_wb_data,
   output fpu_pkg::fpu_id_t          o_wb_id
);
   import fpu_pkg::*;

   localparam int SGN  = `FPU_DW - 1;
   localparam int NOPS = 8;            // UOP_FSGNJ .. UOP_FLE

   logic [NOPS-1:0] dec_op;            // One-hot, bit k = code k+1
   logic            a_nan, b_nan;
   logic            zz;                // Both zeros, any sign
   logic            ord_lt, ord_eq;    // IEEE ordering, +0 == -0

   logic            s1_vld;
   logic [NOPS-1:0] s1_op;
   fpu_id_t         s1_id;
   fpu_word_t       s1_a, s1_b;
   logic            s1_a_nan, s1_b_nan;
   logic            s1_lt, s1_eq, s1_zz;

   logic            s2_vld;
   fpu_id_t         s2_id;
   fpu_word_t       s2_data;

   logic            s1_en, s2_en;      // Stage load enables
   logic            any_nan;
   logic            mm_lt;             // Min/max order, -0 below +0
   fpu_word_t       mm_min, mm_max, res;

   always_comb
   begin
      for (int k = 0; k < NOPS; k++)
         dec_op[k] = (i_fu_uop == fpu_uop_e'(k + 1));
   end

   // Stage one compare
   always_comb
   begin
      a_nan  = (&i_fu_rs1[30:23]) & (|i_fu_rs1[22:0]);
      b_nan  = (&i_fu_rs2[30:23]) & (|i_fu_rs2[22:0]);
      zz     = ~|i_fu_rs1[SGN-1:0] & ~|i_fu_rs2[SGN-1:0];
      ord_eq = (i_fu_rs1 == i_fu_rs2) | zz;
      case ({i_fu_rs1[SGN], i_fu_rs2[SGN]})
         2'b10:   ord_lt = ~zz;                                   // Neg vs pos
         2'b01:   ord_lt = 1'b0;
         2'b00:   ord_lt = i_fu_rs1[SGN-1:0] < i_fu_rs2[SGN-1:0];
         default: ord_lt = i_fu_rs1[SGN-1:0] > i_fu_rs2[SGN-1:0]; // Both neg, mag flips
      endcase
   end

   // Advance when empty or when downstream drains
   assign s2_en      = ~s2_vld | i_wb_ready;
   assign s1_en      = ~s1_vld | s2_en;
   assign o_fu_ready = s1_en;

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         s1_vld <= 1'b0;
         s2_vld <= 1'b0;
      end
      else if (i_flush)
      begin
         s1_vld <= 1'b0;
         s2_vld <= 1'b0;
      end
      else
      begin
         if (s1_en)
            s1_vld <= i_fu_valid;
         if (s2_en)
            s2_vld <= s1_vld;
      end
   end

   always_ff @(posedge clk)
   begin
      if (s1_en && i_fu_valid)
      begin
         s1_op    <= dec_op;
         s1_id    <= i_fu_id;
         s1_a     <= i_fu_rs1;
         s1_b     <= i_fu_rs2;
         s1_a_nan <= a_nan;
         s1_b_nan <= b_nan;
         s1_lt    <= ord_lt;
         s1_eq    <= ord_eq;
         s1_zz    <= zz;
      end
      if (s2_en && s1_vld)
      begin
         s2_data <= res;
         s2_id   <= s1_id;
      end
   end

   // Stage two result select
   always_comb
   begin
      any_nan = s1_a_nan | s1_b_nan;
      mm_lt   = s1_lt | (s1_zz & s1_a[SGN] & ~s1_b[SGN]);
      if (s1_a_nan && s1_b_nan)
      begin
         mm_min = FPU_CANON_NAN;
         mm_max = FPU_CANON_NAN;
      end
      else if (s1_a_nan)
      begin
         mm_min = s1_b;    // Other operand wins
         mm_max = s1_b;
      end
      else if (s1_b_nan)
      begin
         mm_min = s1_a;
         mm_max = s1_a;
      end
      else
      begin
         mm_min = mm_lt ? s1_a : s1_b;
         mm_max = mm_lt ? s1_b : s1_a;
      end
      // One-hot AND-OR mux
      res = ({`FPU_DW{s1_op[UOP_FSGNJ-1]}}  & {s1_b[SGN], s1_a[SGN-1:0]})
          | ({`FPU_DW{s1_op[UOP_FSGNJN-1]}} & {~s1_b[SGN], s1_a[SGN-1:0]})
          | ({`FPU_DW{s1_op[UOP_FSGNJX-1]}} & {s1_a[SGN] ^ s1_b[SGN], s1_a[SGN-1:0]})
          | ({`FPU_DW{s1_op[UOP_FMIN-1]}}   & mm_min)
          | ({`FPU_DW{s1_op[UOP_FMAX-1]}}   & mm_max)
          | fpu_word_t'(s1_op[UOP_FEQ-1] & ~any_nan & s1_eq)
          | fpu_word_t'(s1_op[UOP_FLT-1] & ~any_nan & s1_lt)
          | fpu_word_t'(s1_op[UOP_FLE-1] & ~any_nan & (s1_lt | s1_eq));
   end

   assign o_wb_valid = s2_vld;
   assign o_wb_data  = s2_data;
   assign o_wb_id    = s2_id;

endmodule

`default_nettype wire

// ==== fpu_pipeline.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP issue slot, issue queue in front of the two-stage exec unit
// Best case dispatch to o_wb_valid is three edges; i_flush hits both halves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "fpu_defs.svh"

module fpu_pipeline
(
   input  wire                       clk,
   input  wire                       i_rst_n,
   input  wire                       i_flush,
   // Dispatch
   input  wire                       i_issue_valid,
   output logic                      o_issue_ready,
   input  wire fpu_pkg::fpu_uop_e    i_uop,
   input  wire fpu_pkg::fpu_id_t     i_id,
   input  wire                       i_rs1_rdy,
   input  wire fpu_pkg::fpu_word_t   i_rs1_dat,
   input  wire fpu_pkg::fpu_reg_t    i_rs1_addr,
   input  wire                       i_rs2_rdy,
   input  wire fpu_pkg::fpu_word_t   i_rs2_dat,
   input  wire fpu_pkg::fpu_reg_t    i_rs2_addr,
   // Bypass
   input  wire                       i_byp_valid,
   input  wire                       i_byp_we,
   input  wire fpu_pkg::fpu_word_t   i_byp_data,
   input  wire fpu_pkg::fpu_reg_t    i_byp_addr,
   // Writeback
   output logic                      o_wb_valid,
   input  wire                       i_wb_ready,
   output fpu_pkg::fpu_word_t        o_wb_data,
   output fpu_pkg::fpu_id_t          o_wb_id
);
   import fpu_pkg::*;

   logic      fu_valid;
   logic      fu_ready;
   fpu_uop_e  fu_uop;
   fpu_id_t   fu_id;
   fpu_word_t fu_rs1;
   fpu_word_t fu_rs2;

   fpu_issue_queue u_issue_queue
   (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_flush       (i_flush),
      .i_issue_valid (i_issue_valid),
      .o_issue_ready (o_issue_ready),
      .i_uop         (i_uop),
      .i_id          (i_id),
      .i_rs1_rdy     (i_rs1_rdy),
      .i_rs1_dat     (i_rs1_dat),
      .i_rs1_addr    (i_rs1_addr),
      .i_rs2_rdy     (i_rs2_rdy),
      .i_rs2_dat     (i_rs2_dat),
      .i_rs2_addr    (i_rs2_addr),
      .i_byp_valid   (i_byp_valid),
      .i_byp_we      (i_byp_we),
      .i_byp_data    (i_byp_data),
      .i_byp_addr    (i_byp_addr),
      .o_fu_valid    (fu_valid),
      .i_fu_ready    (fu_ready),
      .o_fu_uop      (fu_uop),
      .o_fu_id       (fu_id),
      .o_fu_rs1      (fu_rs1),
      .o_fu_rs2      (fu_rs2)
   );

   fpu_exec u_exec
   (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_flush    (i_flush),
      .i_fu_valid (fu_valid),
      .o_fu_ready (fu_ready),
      .i_fu_uop   (fu_uop),
      .i_fu_id    (fu_id),
      .i_fu_rs1   (fu_rs1),
      .i_fu_rs2   (fu_rs2),
      .o_wb_valid (o_wb_valid),
      .i_wb_ready (i_wb_ready),
      .o_wb_data  (o_wb_data),
      .o_wb_id    (o_wb_id)
   );

endmodule

`default_nettype wire

// ==== tb_fpu_pipeline.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the FP issue slot, needs a timing-aware simulator
// Expected results come from a behavioral model of the FP result rules
// Ids wrap mod 16; dispatch stalls until a recycled id has retired
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_fpu_pipeline;
   timeunit 1ns;
   timeprecision 1ps;

   import fpu_pkg::*;

   localparam int          T_CLK  = 4;
   localparam int          N_DIR  = 64;           // 8 codes x 8 operand pairs
   localparam int          N_RAND = 48;
   localparam int          N_OPS  = 1 + N_DIR + 3 + 6 + N_RAND + 7;
   localparam int          OP_CYC = 40;           // Worst case per op, with stalls
   localparam logic [31:0] SEED   = 32'hf0db_9141;

   logic      clk;
   logic      i_rst_n, i_flush;
   logic      i_issue_valid, o_issue_ready;
   fpu_uop_e  i_uop;
   fpu_id_t   i_id;
   logic      i_rs1_rdy, i_rs2_rdy;
   fpu_word_t i_rs1_dat, i_rs2_dat;
   fpu_reg_t  i_rs1_addr, i_rs2_addr;
   logic      i_byp_valid, i_byp_we;
   fpu_word_t i_byp_data;
   fpu_reg_t  i_byp_addr;
   logic      o_wb_valid, i_wb_ready;
   fpu_word_t o_wb_data;
   fpu_id_t   o_wb_id;

   // Scoreboard, one slot per ROB id
   logic      pend [16];
   fpu_word_t exp_data [16];
   fpu_id_t   next_id, last_id;
   logic      held;                  // Output stalled at last edge
   fpu_id_t   held_id;
   fpu_word_t held_data;
   logic [255:0] bp_pat;             // Random i_wb_ready pattern

   fpu_pipeline dut (.*);

   initial clk = 1'b0;
   always #(T_CLK / 2) clk = ~clk;

   function automatic logic is_nan(input fpu_word_t x);
      return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
   endfunction

   // Unsigned order of keys follows float order, -0 just below +0
   function automatic logic [31:0] order_key(input fpu_word_t x);
      return x[31] ? ~x : (x | 32'h8000_0000);
   endfunction

   function automatic fpu_word_t ref_result(input fpu_uop_e op, input fpu_word_t a,
                                            input fpu_word_t b);
      logic      nan_a, nan_b, zeros, lt, eq;
      fpu_word_t r;
      nan_a = is_nan(a);
      nan_b = is_nan(b);
      zeros = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
      lt    = order_key(a) < order_key(b);
      eq    = (a == b) || zeros;   // +0 == -0 for compares
      r     = 32'd0;
      case (op)
         UOP_FSGNJ:  r = {b[31], a[30:0]};
         UOP_FSGNJN: r = {~b[31], a[30:0]};
         UOP_FSGNJX: r = {a[31] ^ b[31], a[30:0]};
         UOP_FMIN, UOP_FMAX:
         begin
            if (nan_a && nan_b)
               r = FPU_CANON_NAN;
            else if (nan_a)
               r = b;              // Non-NaN side wins
            else if (nan_b)
               r = a;
            else if (op == UOP_FMIN)
               r = lt ? a : b;
            else
               r = lt ? b : a;
         end
         UOP_FEQ: r[0] = !nan_a && !nan_b && eq;
         UOP_FLT: r[0] = !nan_a && !nan_b && lt && !zeros;
         UOP_FLE: r[0] = !nan_a && !nan_b && (lt || eq);
         default: r = 32'd0;
      endcase
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   function automatic int pending_count();
      int n;
      n = 0;
      for (int i = 0; i < 16; i++)
         n += int'(pend[i]);
      return n;
   endfunction

   // Entered and left on a falling edge
   task automatic dispatch(input fpu_uop_e op, input fpu_word_t a, input fpu_word_t b,
                           input logic a_rdy = 1'b1, input fpu_reg_t a_reg = '0,
                           input logic b_rdy = 1'b1, input fpu_reg_t b_reg = '0);
      last_id = next_id;
      next_id = next_id + 4'd1;
      while (pend[last_id])
         @(negedge clk);           // Id still in flight
      i_issue_valid = 1'b1;
      i_uop         = op;
      i_id          = last_id;
      i_rs1_rdy     = a_rdy;
      i_rs1_dat     = a;
      i_rs1_addr    = a_reg;
      i_rs2_rdy     = b_rdy;
      i_rs2_dat     = b;
      i_rs2_addr    = b_reg;
      while (!o_issue_ready)
         @(negedge clk);
      @(posedge clk);              // Accepted here
      @(negedge clk);
      i_issue_valid     = 1'b0;
      exp_data[last_id] = ref_result(op, a, b);
      pend[last_id]     = 1'b1;
   endtask

   task automatic wait_drain();
      while (pending_count() != 0)
         @(negedge clk);
   endtask

   // Writeback monitor, handshake seen at the rising edge
   always @(posedge clk)
   begin
      if (i_rst_n)
      begin
         if (held)
         begin
            check_val("o_wb_valid", 32'(o_wb_valid), 32'd1);
            check_val("o_wb_id", 32'(o_wb_id), 32'(held_id));
            check_val("o_wb_data", o_wb_data, held_data);
         end
         held      = o_wb_valid && !i_wb_ready && !i_flush;
         held_id   = o_wb_id;
         held_data = o_wb_data;
         if (o_wb_valid && i_wb_ready)
         begin
            if (!pend[o_wb_id])
               abort_run($sformatf("Result for id %0d that is not in flight", o_wb_id));
            else
            begin
               check_val("o_wb_data", o_wb_data, exp_data[o_wb_id]);
               pend[o_wb_id] = 1'b0;
            end
         end
      end
   end

   task automatic test_reset_latency();
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd0);
      check_val("o_issue_ready", 32'(o_issue_ready), 32'd1);
      dispatch(UOP_FSGNJ, 32'h3f80_0000, 32'hc000_0000);
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd0);     // After acceptance edge
      @(negedge clk);
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd0);
      @(negedge clk);
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd1);     // Third edge
      check_val("o_wb_id", 32'(o_wb_id), 32'(last_id));
      wait_drain();
   endtask

   task automatic test_all_codes();
      fpu_word_t va [8];
      fpu_word_t vb [8];
      // Signed zeros both ways, one NaN, two NaNs, negatives, equal, mixed sign
      va = '{32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000, 32'h3f80_0000,
             32'hffc0_0001, 32'hc020_0000, 32'h3fc0_0000, 32'hc040_0000};
      vb = '{32'h8000_0000, 32'h0000_0000, 32'h3f80_0000, 32'h7f80_0001,
             32'h7fc0_0000, 32'hbf80_0000, 32'h3fc0_0000, 32'h4000_0000};
      for (int c = 1; c <= 8; c++)
         for (int p = 0; p < 8; p++)
            dispatch(fpu_uop_e'(4'(c)), va[p], vb[p]);
      wait_drain();
   endtask

   task automatic test_wakeup();
      fpu_id_t wait_id;
      fpu_id_t fast_id;
      dispatch(UOP_FMAX, 32'hdead_beef, 32'h3f80_0000, 1'b0, 5'd5);  // rs1 on f5
      wait_id = last_id;
      dispatch(UOP_FSGNJN, 32'h4120_0000, 32'h8000_0000);
      fast_id = last_id;
      while (pend[fast_id])
         @(negedge clk);
      // Write to another register, must not wake it
      i_byp_valid = 1'b1;
      i_byp_we    = 1'b1;
      i_byp_addr  = 5'd6;
      i_byp_data  = 32'h1111_1111;
      @(negedge clk);
      i_byp_valid = 1'b0;
      repeat (4) @(negedge clk);
      check_val("waiting_entry_pending", 32'(pend[wait_id]), 32'd1);
      exp_data[wait_id] = ref_result(UOP_FMAX, 32'h4040_0000, 32'h3f80_0000);
      i_byp_valid = 1'b1;
      i_byp_addr  = 5'd5;
      i_byp_data  = 32'h4040_0000;
      @(negedge clk);
      // Same-cycle hit on an arriving rs2
      i_byp_addr = 5'd7;
      i_byp_data = 32'hc0a0_0000;
      dispatch(UOP_FSGNJX, 32'h3f80_0000, 32'h5555_5555, 1'b1, 5'd0, 1'b0, 5'd7);
      i_byp_valid       = 1'b0;
      exp_data[last_id] = ref_result(UOP_FSGNJX, 32'h3f80_0000, 32'hc0a0_0000);
      wait_drain();
   endtask

   task automatic test_backpressure();
      i_wb_ready = 1'b0;
      for (int k = 0; k < 6; k++)       // Two stages plus four entries
         dispatch(fpu_uop_e'(4'(k + 1)), fpu_word_t'(32'h3f80_0000 + (k << 20)),
                  fpu_word_t'(32'hc000_0000 - (k << 21)));
      check_val("o_issue_ready", 32'(o_issue_ready), 32'd0);
      repeat (3) @(negedge clk);
      check_val("o_issue_ready", 32'(o_issue_ready), 32'd0);
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd1);
      i_wb_ready = 1'b1;
      wait_drain();
   endtask

   task automatic test_random();
      logic stop;
      stop = 1'b0;
      fork
         begin
            for (int k = 0; k < N_RAND; k++)
               dispatch(fpu_uop_e'(4'($urandom_range(8, 1))), rand_word(), rand_word());
            stop = 1'b1;
         end
         begin
            for (int k = 0; !stop; k++)
            begin
               i_wb_ready = bp_pat[k % 256];
               @(negedge clk);
            end
         end
      join
      i_wb_ready = 1'b1;
      wait_drain();
   endtask

   // Specials often enough to hit NaN, zeros and equal pairs
   function automatic fpu_word_t rand_word();
      fpu_word_t sp [6];
      sp = '{32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000,
             32'hff80_0001, 32'h3f80_0000, 32'hbf80_0000};
      if ($urandom_range(3) == 0)
         return sp[$urandom_range(5)];
      return $urandom();
   endfunction

   task automatic test_flush();
      i_wb_ready = 1'b0;
      for (int k = 0; k < 6; k++)
         dispatch(UOP_FLE, fpu_word_t'(32'h4000_0000 + k), 32'h4000_0002);
      check_val("o_issue_ready", 32'(o_issue_ready), 32'd0);
      check_val("o_wb_valid", 32'(o_wb_valid), 32'd1);
      i_flush = 1'b1;
      @(negedge clk);
      i_flush = 1'b0;
      for (int i = 0; i < 16; i++)
         pend[i] = 1'b0;                // Flushed work never returns
      i_wb_ready = 1'b1;
      repeat (8)
      begin
         check_val("o_wb_valid", 32'(o_wb_valid), 32'd0);
         @(negedge clk);
      end
      check_val("o_issue_ready", 32'(o_issue_ready), 32'd1);
      dispatch(UOP_FEQ, 32'h3f80_0000, 32'h3f80_0000);
      wait_drain();
   endtask

   // Watchdog
   initial
   begin
      #(N_OPS * OP_CYC * T_CLK);
      abort_run("Timeout, the DUT stopped returning results");
   end

   initial
   begin
      void'($urandom(SEED));
      for (int k = 0; k < 256; k++)
         bp_pat[k] = ($urandom_range(3) != 0);   // Ready 3 cycles in 4
      for (int i = 0; i < 16; i++)
         pend[i] = 1'b0;
      {next_id, last_id, held} = '0;
      i_rst_n       = 1'b0;
      i_flush       = 1'b0;
      i_issue_valid = 1'b0;
      i_uop         = UOP_NONE;
      i_id          = '0;
      {i_rs1_rdy, i_rs1_dat, i_rs1_addr} = '0;
      {i_rs2_rdy, i_rs2_dat, i_rs2_addr} = '0;
      {i_byp_valid, i_byp_we, i_byp_data, i_byp_addr} = '0;
      i_wb_ready    = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_rst_n = 1'b1;
      test_reset_latency();
      test_all_codes();
      test_wakeup();
      test_backpressure();
      test_random();
      test_flush();
      repeat (4) @(negedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
fpu_pkg.sv
fpu_issue_queue.sv
fpu_exec.sv
fpu_pipeline.sv
tb_fpu_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Build the FP issue slot testbench with Verilator and run it
# Passes only when the pass message shows up in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
   --top-module tb_fpu_pipeline -Mdir obj_dir -f filelist.f \
   && ./obj_dir/Vtb_fpu_pipeline | tee /dev/stderr | grep "TEST OK" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

exit 0
